/* test/ex_tb_vectors.svh */
task automatic load_table();
    // inst, op1, op2, reg2, rdata, jump offset, flags, wdata, mem wdata, eflags
    add_row('h2b3, 'h5, 'h7, 0, 0, 0, 3'b001, 'hc, 0, 4'b1000);
    add_row('h400002b3, 'h5, 'h7, 0, 0, 0, 3'b001, 'hfffffffe, 0, 4'b1000);
    add_row('h12b3, 'h1, 'h24, 0, 0, 0, 3'b001, 'h10, 0, 4'b1000);
    add_row('h22b3, 'hfffffffe, 'h1, 0, 0, 0, 3'b001, 'h1, 0, 4'b1000);
    add_row('h32b3, 'hfffffffe, 'h1, 0, 0, 0, 3'b001, 'h0, 0, 4'b1000);
    add_row('h42b3, 'hff00ff00, 'h0ff00ff0, 0, 0, 0, 3'b001, 'hf0f0f0f0, 0, 4'b1000);
    add_row('h52b3, 'h80000000, 'h4, 0, 0, 0, 3'b001, 'h08000000, 0, 4'b1000);
    add_row('h400052b3, 'h80000000, 'h4, 0, 0, 0, 3'b001, 'hf8000000, 0, 4'b1000);
    add_row('h62b3, 'hf0, 'hf00, 0, 0, 0, 3'b001, 'hff0, 0, 4'b1000);
    add_row('h72b3, 'hff0f, 'hff0, 0, 0, 0, 3'b001, 'hf00, 0, 4'b1000);
    // addi with imm bit 10 set, srai, lui, auipc, mul
    add_row('hff000293, 'h100, 'hfffffff0, 0, 0, 0, 3'b001, 'hf0, 0, 4'b1000);
    add_row('h40805293, 'h80000000, 'h8, 0, 0, 0, 3'b001, 'hff800000, 0, 4'b1000);
    add_row('h123452b7, 'h0, 'h12345000, 0, 0, 0, 3'b001, 'h12345000, 0, 4'b1000);
    add_row('h1297, 'h2000, 'h1000, 0, 0, 0, 3'b001, 'h3000, 0, 4'b1000);
    add_row('h20002b3, 'h3, 'h4, 0, 0, 0, 3'b001, 'h0, 0, 4'b1000);
    // loads from bytes 0f f0 80 7f, low lane first
    add_row('h283, 'h1000, 'h0, 0, 'h7f80f00f, 0, 3'b001, 'hf, 0, 4'b1100);
    add_row('h283, 'h1000, 'h1, 0, 'h7f80f00f, 0, 3'b001, 'hfffffff0, 0, 4'b1100);
    add_row('h283, 'h1000, 'h2, 0, 'h7f80f00f, 0, 3'b001, 'hffffff80, 0, 4'b1100);
    add_row('h283, 'h1000, 'h3, 0, 'h7f80f00f, 0, 3'b001, 'h7f, 0, 4'b1100);
    add_row('h4283, 'h1000, 'h1, 0, 'h7f80f00f, 0, 3'b001, 'hf0, 0, 4'b1100);
    add_row('h4283, 'h1000, 'h2, 0, 'h7f80f00f, 0, 3'b001, 'h80, 0, 4'b1100);
    add_row('h1283, 'h1000, 'h0, 0, 'h7f80f00f, 0, 3'b001, 'hfffff00f, 0, 4'b1100);
    add_row('h1283, 'h1000, 'h2, 0, 'h7f80f00f, 0, 3'b001, 'h7f80, 0, 4'b1100);
    add_row('h5283, 'h1000, 'h0, 0, 'h7f80f00f, 0, 3'b001, 'hf00f, 0, 4'b1100);
    add_row('h2283, 'h1000, 'h0, 0, 'h7f80f00f, 0, 3'b001, 'h7f80f00f, 0, 4'b1100);
    // stores merge into the read word
    add_row('h23, 'h1000, 'h0, 'haabbccdd, 'h11223344, 0, 3'b000, 0, 'h112233dd, 4'b0110);
    add_row('h23, 'h1000, 'h1, 'haabbccdd, 'h11223344, 0, 3'b000, 0, 'h1122dd44, 4'b0110);
    add_row('h23, 'h1000, 'h2, 'haabbccdd, 'h11223344, 0, 3'b000, 0, 'h11dd3344, 4'b0110);
    add_row('h23, 'h1000, 'h3, 'haabbccdd, 'h11223344, 0, 3'b000, 0, 'hdd223344, 4'b0110);
    add_row('h1023, 'h1000, 'h0, 'haabbccdd, 'h11223344, 0, 3'b000, 0, 'h1122ccdd, 4'b0110);
    add_row('h1023, 'h1000, 'h2, 'haabbccdd, 'h11223344, 0, 3'b000, 0, 'hccdd3344, 4'b0110);
    add_row('h2023, 'h1000, 'h0, 'haabbccdd, 'h11223344, 0, 3'b000, 0, 'haabbccdd, 4'b0110);
    // branches, taken then not taken
    add_row('h63, 'h5, 'h5, 0, 0, 'h40, 3'b000, 0, 0, 4'b0001);
    add_row('h63, 'h5, 'h6, 0, 0, 'h40, 3'b000, 0, 0, 4'b0000);
    add_row('h1063, 'h5, 'h6, 0, 0, 'h40, 3'b000, 0, 0, 4'b0001);
    add_row('h1063, 'h5, 'h5, 0, 0, 'h40, 3'b000, 0, 0, 4'b0000);
    add_row('h4063, 'hffffffff, 'h1, 0, 0, 'h40, 3'b000, 0, 0, 4'b0001);
    add_row('h4063, 'h1, 'hffffffff, 0, 0, 'h40, 3'b000, 0, 0, 4'b0000);
    add_row('h5063, 'h1, 'hffffffff, 0, 0, 'h40, 3'b000, 0, 0, 4'b0001);
    add_row('h5063, 'hffffffff, 'h1, 0, 0, 'h40, 3'b000, 0, 0, 4'b0000);
    add_row('h6063, 'h1, 'hffffffff, 0, 0, 'h40, 3'b000, 0, 0, 4'b0001);
    add_row('h6063, 'hffffffff, 'h1, 0, 0, 'h40, 3'b000, 0, 0, 4'b0000);
    add_row('h7063, 'hffffffff, 'h1, 0, 0, 'h40, 3'b000, 0, 0, 4'b0001);
    add_row('h7063, 'h1, 'hffffffff, 0, 0, 'h40, 3'b000, 0, 0, 4'b0000);
    // jal, jalr and fence
    add_row('h2ef, 'h2000, 'h4, 0, 0, 'h100, 3'b001, 'h2004, 0, 4'b1001);
    add_row('h2e7, 'h2000, 'h4, 0, 0, 'h80, 3'b001, 'h2004, 0, 4'b1001);
    add_row('hf, 'h0, 'h0, 0, 0, 'h4, 3'b000, 0, 0, 4'b0001);
    // interrupt over add, store and div, then an add that must see no hold
    add_row('h2b3, 'h5, 'h7, 0, 0, 0, 3'b011, 'hc, 0, 4'b0001);
    add_row('h23, 'h1000, 'h0, 'haabbccdd, 'h11223344, 0, 3'b010, 0, 0, 4'b0001);
    add_row('h2004533, 'hffffffec, 'h3, 'h3, 0, 'h80, 3'b011, 0, 0, 4'b0001);
    add_row('h2b3, 'h5, 'h7, 0, 0, 0, 3'b001, 'hc, 0, 4'b1000);
    // divides into x10, divisor in reg2
    add_row('h2004533, 'hffffffec, 0, 'h3, 0, 'h80, 3'b101, 'hfffffffa, 0, 4'b0000);
    add_row('h2006533, 'hffffffec, 0, 'h3, 0, 'h80, 3'b101, 'hfffffffe, 0, 4'b0000);
    add_row('h2005533, 'hffffffec, 0, 'h3, 0, 'h80, 3'b101, 'h5555554e, 0, 4'b0000);
    add_row('h2007533, 'hffffffec, 0, 'h3, 0, 'h80, 3'b101, 'h2, 0, 4'b0000);
    add_row('h2004533, 'hfffffff9, 0, 'h0, 0, 'h80, 3'b101, 'hffffffff, 0, 4'b0000);
    add_row('h2006533, 'hfffffff9, 0, 'h0, 0, 'h80, 3'b101, 'hfffffff9, 0, 4'b0000);
    add_row('h2005533, 'h7, 0, 'h0, 0, 'h80, 3'b101, 'hffffffff, 0, 4'b0000);
    add_row('h2007533, 'h7, 0, 'h0, 0, 'h80, 3'b101, 'h7, 0, 4'b0000);
    add_row('h2004533, 'h80000000, 0, 'hffffffff, 0, 'h80, 3'b101, 'h80000000, 0, 4'b0000);
    add_row('h2006533, 'h80000000, 0, 'hffffffff, 0, 'h80, 3'b101, 'h0, 0, 4'b0000);
endtask

/* test/ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_tb
    import ex_pkg::*;
();

    localparam logic [31:0] JUMP_BASE = 32'h0000_2000;
    localparam logic [31:0] INT_VEC   = 32'h0000_0800;
    localparam logic [31:0] NOP_INST  = 32'h0000_0013;
    localparam int          SEED      = 6770;
    localparam int          MAX_ROWS  = 80;
    localparam int          RAND_DIVS = 20;
    localparam int          DIV_WAIT  = 40;
    localparam int          DIV_LAT   = 33;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] reg2;
        logic [31:0] rdata;
        logic [31:0] jofs;
        logic        div;
        logic        intr;
        logic        reg_we;
        logic [31:0] exp_wdata;
        logic [31:0] exp_mdata;
        logic        exp_we;
        logic        exp_req;
        logic        exp_mwe;
        logic        exp_jump;
    } vec_t;

    logic        clk;
    logic        rst_n;
    ex_issue_t   issue;
    logic [31:0] mem_rdata;
    logic        int_assert;
    logic [31:0] int_addr;
    rf_wr_t      rf_wr;
    mem_req_t    mem_req;
    redirect_t   redir;

    vec_t vecs [MAX_ROWS];
    int   num_rows;
    int   num_divs;
    int   cur_row;
    int   checks;
    int   mismatches;
    int   failures;
    int   cycles;
    int   limit;

    ex_top i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .issue_i      (issue),
        .mem_rdata_i  (mem_rdata),
        .int_assert_i (int_assert),
        .int_addr_i   (int_addr),
        .rf_wr_o      (rf_wr),
        .mem_o        (mem_req),
        .redirect_o   (redir)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout, run still going after %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // flags are {div, intr, reg_we}
    // eflags are {we, req, mem we, jump}
    task automatic add_row(input logic [31:0] inst, input logic [31:0] op1,
                           input logic [31:0] op2, input logic [31:0] reg2,
                           input logic [31:0] rdata, input logic [31:0] jofs,
                           input logic [2:0] flags, input logic [31:0] wdata,
                           input logic [31:0] mdata, input logic [3:0] eflags);
        vecs[num_rows] = {inst, op1, op2, reg2, rdata, jofs, flags, wdata, mdata, eflags};
        if (flags[2]) begin
            num_divs++;
        end
        num_rows++;
    endtask

    `include "ex_tb_vectors.svh"

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%08h expected 0x%08h at row %0d",
                     name, got, exp, cur_row);
        end
    endtask

    function automatic ex_issue_t make_issue(input logic [31:0] inst, input logic [31:0] op1,
                                             input logic [31:0] op2, input logic [31:0] reg2,
                                             input logic [31:0] jofs, input logic reg_we);
        ex_issue_t s;
        s.inst       = inst;
        s.op1        = op1;
        s.op2        = op2;
        s.op1_jump   = JUMP_BASE;
        s.op2_jump   = jofs;
        s.reg1_rdata = op1;
        s.reg2_rdata = reg2;
        s.reg_we     = reg_we;
        s.reg_waddr  = inst[11:7];
        return s;
    endfunction

    // truncating division with the RISC-V zero divisor and overflow results
    function automatic logic [31:0] ref_divide(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        q;
        logic [31:0]        r;
        sa = a;
        sb = b;
        if (b == 0) begin
            q = '1;
            r = a;
        end else if (!f3[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = 0;
        end else if (!f3[0]) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = a / b;
            r = a % b;
        end
        // rem and remu have funct3 bit 1 set
        return f3[1] ? r : q;
    endfunction

    task automatic apply_row(input vec_t v);
        @(posedge clk);
        issue      <= make_issue(v.inst, v.op1, v.op2, v.reg2, v.jofs, v.reg_we);
        mem_rdata  <= v.rdata;
        int_assert <= v.intr;
        @(negedge clk);
        compare("rf_wr_o.we", rf_wr.we, v.exp_we);
        compare("rf_wr_o.waddr", rf_wr.waddr, v.inst[11:7]);
        compare("rf_wr_o.wdata", rf_wr.wdata, v.exp_wdata);
        compare("mem_o.req", mem_req.req, v.exp_req);
        compare("mem_o.we", mem_req.we, v.exp_mwe);
        if (v.exp_req) begin
            compare("mem_o.raddr", mem_req.raddr, v.op1 + v.op2);
            compare("mem_o.waddr", mem_req.waddr, v.op1 + v.op2);
            compare("mem_o.size", mem_req.size, v.inst[13:12]);
        end
        if (v.exp_mwe) begin
            compare("mem_o.wdata", mem_req.wdata, v.exp_mdata);
        end
        compare("redirect_o.hold", redir.hold, 1'b0);
        compare("redirect_o.jump", redir.jump, v.exp_jump);
        if (v.exp_jump) begin
            compare("redirect_o.jump_addr", redir.jump_addr,
                    v.intr ? INT_VEC : JUMP_BASE + v.jofs);
        end
    endtask

    task automatic run_divide(input logic [31:0] inst, input logic [31:0] a,
                              input logic [31:0] b, input logic [31:0] jofs,
                              input logic [31:0] expected);
        int   waited;
        logic got;
        @(posedge clk);
        issue      <= make_issue(inst, a, b, b, jofs, 1'b1);
        int_assert <= 1'b0;
        @(negedge clk);
        compare("redirect_o.hold", redir.hold, 1'b1);
        compare("redirect_o.jump", redir.jump, 1'b1);
        compare("redirect_o.jump_addr", redir.jump_addr, JUMP_BASE + jofs);
        compare("rf_wr_o.we", rf_wr.we, 1'b0);
        compare("mem_o.req", mem_req.req, 1'b0);
        // upstream re-presents a bubble with a write enable while held
        @(posedge clk);
        issue <= make_issue(NOP_INST, 0, 0, 0, 0, 1'b1);
        waited = 0;
        got    = 1'b0;
        while (!got && waited < DIV_WAIT) begin
            @(negedge clk);
            waited++;
            got = rf_wr.we;
            compare("redirect_o.hold", redir.hold, 1'b1);
        end
        if (!got) begin
            failures++;
            $display("divide result never arrived for instruction 0x%08h", inst);
        end else begin
            if (waited != DIV_LAT) begin
                failures++;
                $display("divide result arrived %0d cycles after issue instead of %0d",
                         waited, DIV_LAT);
            end
            compare("rf_wr_o.wdata", rf_wr.wdata, expected);
            compare("rf_wr_o.waddr", rf_wr.waddr, inst[11:7]);
            // bubble without a write enable once the result is out
            @(posedge clk);
            issue <= make_issue(NOP_INST, 0, 0, 0, 0, 1'b0);
            @(negedge clk);
            compare("rf_wr_o.we", rf_wr.we, 1'b0);
            compare("redirect_o.hold", redir.hold, 1'b0);
        end
    endtask

    initial begin
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] inst;
        int          sel;
        clk        = 1'b0;
        rst_n      = 1'b0;
        issue      = '0;
        mem_rdata  = '0;
        int_assert = 1'b0;
        int_addr   = INT_VEC;
        void'($urandom(SEED));
        load_table();
        limit = 16 + 2 * num_rows + DIV_WAIT * (num_divs + RAND_DIVS) + 200;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (cur_row = 0; cur_row < num_rows; cur_row++) begin
            if (vecs[cur_row].div) begin
                run_divide(vecs[cur_row].inst, vecs[cur_row].op1, vecs[cur_row].reg2,
                           vecs[cur_row].jofs, vecs[cur_row].exp_wdata);
            end else begin
                apply_row(vecs[cur_row]);
            end
        end
        for (int k = 0; k < RAND_DIVS; k++) begin
            f3  = {1'b1, 2'($urandom % 4)};
            rd  = 5'(1 + $urandom % 31);
            a   = $urandom;
            sel = $urandom % 4;
            case (sel)
                0: b = 0;
                1: begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end
                default: b = $urandom >> ($urandom % 32);
            endcase
            inst    = {7'b0000001, 10'b0, f3, rd, OPC_OP};
            cur_row = num_rows + k;
            run_divide(inst, a, b, 32'h40, ref_divide(f3, a, b));
        end
        $display("checks %0d mismatches %0d failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_lsu_align.sv
verilog/ex_divider.sv
verilog/ex_commit.sv
verilog/ex_top.sv
test/ex_tb.sv

/* verilog/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  wire ex_issue_t  issue_i,
    input  wire op_class_e  op_class_i,
    input  wire alu_op_e    alu_op_i,
    output logic [XLEN-1:0] result_o,
    output logic            taken_o
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic            ge_signed;
    logic            ge_unsigned;
    logic            equal;
    logic            cond;

    assign op1   = issue_i.op1;
    assign op2   = issue_i.op2;
    assign shamt = op2[4:0];

    // shared by slt and the branches
    assign ge_signed   = $signed(op1) >= $signed(op2);
    assign ge_unsigned = op1 >= op2;
    assign equal       = op1 == op2;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = op1 + op2;
            ALU_SUB:  result_o = op1 - op2;
            ALU_SLL:  result_o = op1 << shamt;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, ~ge_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, ~ge_unsigned};
            ALU_XOR:  result_o = op1 ^ op2;
            ALU_SRL:  result_o = op1 >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(op1) >>> shamt);
            ALU_OR:   result_o = op1 | op2;
            ALU_AND:  result_o = op1 & op2;
            default:  result_o = '0;
        endcase
    end

    always_comb begin
        case (issue_i.inst.r.funct3)
            F3_BEQ:  cond = equal;
            F3_BNE:  cond = ~equal;
            F3_BLT:  cond = ~ge_signed;
            F3_BGE:  cond = ge_signed;
            F3_BLTU: cond = ~ge_unsigned;
            F3_BGEU: cond = ge_unsigned;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (op_class_i)
            OP_JUMP, OP_FENCE: taken_o = 1'b1;
            OP_BRANCH:         taken_o = cond;
            default:           taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ex_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_commit
    import ex_pkg::*;
(
    input  wire ex_issue_t  issue_i,
    input  wire op_class_e  op_class_i,
    input  wire mem_size_e  size_i,
    input  wire [XLEN-1:0]  alu_result_i,
    input  wire             taken_i,
    input  wire [XLEN-1:0]  addr_i,
    input  wire [XLEN-1:0]  load_data_i,
    input  wire [XLEN-1:0]  store_data_i,
    input  wire             int_assert_i,
    input  wire [XLEN-1:0]  int_addr_i,
    input  wire             div_busy_i,
    input  wire rf_wr_t     div_wr_i,
    output logic            div_start_o,
    output div_req_t        div_req_o,
    output rf_wr_t          rf_wr_o,
    output mem_req_t        mem_o,
    output redirect_t       redirect_o
);

    logic            is_div;
    logic            is_mem;
    logic            is_store;
    logic            suppress;
    logic            jump;
    logic [XLEN-1:0] issue_wdata;

    assign is_div   = op_class_i == OP_DIV;
    assign is_store = op_class_i == OP_STORE;
    assign is_mem   = is_store || op_class_i == OP_LOAD;

    // issued effects dropped while the divider owns the pipeline
    assign suppress = is_div || div_busy_i || div_wr_i.we;
    assign jump     = taken_i || is_div;

    assign div_start_o = is_div && !div_busy_i && !div_wr_i.we && !int_assert_i;
    assign div_req_o   = '{
        dividend: issue_i.reg1_rdata,
        divisor:  issue_i.reg2_rdata,
        funct3:   issue_i.inst.r.funct3,
        rd:       issue_i.reg_waddr
    };

    always_comb begin
        case (op_class_i)
            OP_LOAD:         issue_wdata = load_data_i;
            OP_ALU, OP_JUMP: issue_wdata = alu_result_i;
            default:         issue_wdata = '0;
        endcase
    end

    always_comb begin
        rf_wr_o.we    = !int_assert_i && (div_wr_i.we || (issue_i.reg_we && !suppress));
        rf_wr_o.waddr = div_wr_i.we ? div_wr_i.waddr : issue_i.reg_waddr;
        rf_wr_o.wdata = div_wr_i.we ? div_wr_i.wdata : issue_wdata;

        mem_o.req   = !int_assert_i && !suppress && is_mem;
        mem_o.we    = !int_assert_i && !suppress && is_store;
        mem_o.raddr = is_mem ? addr_i : '0;
        mem_o.waddr = is_mem ? addr_i : '0;
        mem_o.wdata = is_store ? store_data_i : '0;
        mem_o.size  = size_i;

        redirect_o.hold = div_start_o || div_busy_i || div_wr_i.we;
        if (int_assert_i) begin
            redirect_o.jump      = 1'b1;
            redirect_o.jump_addr = int_addr_i;
        end else begin
            redirect_o.jump      = jump;
            redirect_o.jump_addr = jump ? issue_i.op1_jump + issue_i.op2_jump : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/ex_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_decode
    import ex_pkg::*;
(
    input  wire ex_issue_t issue_i,
    output op_class_e      op_class_o,
    output alu_op_e        alu_op_o,
    output mem_size_e      size_o
);

    inst_u inst;

    // integer funct3 to alu operation, sub only exists on the register form
    function automatic alu_op_e int_op(input logic [2:0] funct3, input logic alt,
                                       input logic is_reg);
        alu_op_e op;
        case (funct3)
            F3_ADD:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign inst = issue_i.inst;

    always_comb begin
        op_class_o = OP_NONE;
        alu_op_o   = ALU_ZERO;
        size_o     = SIZE_WORD;
        case (inst.r.opcode)
            OPC_OP_IMM: begin
                op_class_o = OP_ALU;
                alu_op_o   = int_op(inst.r.funct3, inst.i.imm[10], 1'b0);
            end
            OPC_OP: begin
                op_class_o = OP_ALU;
                if (inst.r.funct7 == F7_BASE || inst.r.funct7 == F7_ALT) begin
                    alu_op_o = int_op(inst.r.funct3, inst.i.imm[10], 1'b1);
                end else if (inst.r.funct7 == F7_MULDIV &&
                             inst.r.funct3 inside {F3_DIV, F3_DIVU, F3_REM, F3_REMU}) begin
                    op_class_o = OP_DIV;
                end
                // multiply and unknown funct7 keep ALU_ZERO
            end
            OPC_LOAD: begin
                size_o = mem_size_e'(inst.r.funct3[1:0]);
                if (inst.r.funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                    op_class_o = OP_LOAD;
                end
            end
            OPC_STORE: begin
                size_o = mem_size_e'(inst.r.funct3[1:0]);
                if (inst.r.funct3 inside {F3_SB, F3_SH, F3_SW}) begin
                    op_class_o = OP_STORE;
                end
            end
            OPC_BRANCH: begin
                if (inst.r.funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    op_class_o = OP_BRANCH;
                end
            end
            OPC_JAL, OPC_JALR: begin
                op_class_o = OP_JUMP;
                alu_op_o   = ALU_ADD;
            end
            OPC_LUI, OPC_AUIPC: begin
                op_class_o = OP_ALU;
                alu_op_o   = ALU_ADD;
            end
            OPC_FENCE: op_class_o = OP_FENCE;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ex_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_divider
    import ex_pkg::*;
(
    input  wire           clk_i,
    input  wire           rst_n_i,
    input  wire           start_i,
    input  wire div_req_t req_i,
    output logic          busy_o,
    output rf_wr_t        wr_o
);

    logic                  busy_q;
    logic                  done_q;
    logic [4:0]            count_q;
    logic                  accept;
    logic                  is_signed;
    logic                  dividend_neg;
    logic                  divisor_neg;
    logic [XLEN-1:0]       dividend_abs;
    logic [XLEN-1:0]       divisor_abs;

    logic [XLEN-1:0]       quot_q;
    logic [XLEN-1:0]       rem_q;
    logic [XLEN-1:0]       divisor_q;
    logic [2:0]            funct3_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  neg_quot_q;
    logic                  neg_rem_q;

    logic [XLEN:0]         rem_shift;
    logic [XLEN:0]         rem_diff;
    logic [XLEN-1:0]       quot_res;
    logic [XLEN-1:0]       rem_res;

    assign accept    = start_i && !busy_q;
    assign is_signed = (req_i.funct3 == F3_DIV) || (req_i.funct3 == F3_REM);

    assign dividend_neg = is_signed & req_i.dividend[XLEN-1];
    assign divisor_neg  = is_signed & req_i.divisor[XLEN-1];
    assign dividend_abs = dividend_neg ? -req_i.dividend : req_i.dividend;
    assign divisor_abs  = divisor_neg ? -req_i.divisor : req_i.divisor;

    // one restoring step
    assign rem_shift = {rem_q, quot_q[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            count_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end else if (busy_q) begin
                count_q <= count_q + 5'd1;
                if (count_q == 5'd31) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            quot_q    <= dividend_abs;
            rem_q     <= '0;
            divisor_q <= divisor_abs;
            funct3_q  <= req_i.funct3;
            rd_q      <= req_i.rd;
            // a zero divisor keeps the all ones quotient unsigned
            neg_quot_q <= (dividend_neg ^ divisor_neg) && (req_i.divisor != '0);
            neg_rem_q  <= dividend_neg;
        end else if (busy_q) begin
            if (!rem_diff[XLEN]) begin
                rem_q  <= rem_diff[XLEN-1:0];
                quot_q <= {quot_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q  <= rem_shift[XLEN-1:0];
                quot_q <= {quot_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix, overflow falls out of the magnitudes
    assign quot_res = neg_quot_q ? -quot_q : quot_q;
    assign rem_res  = neg_rem_q ? -rem_q : rem_q;

    assign busy_o = busy_q;
    assign wr_o   = '{
        we:    done_q,
        waddr: rd_q,
        wdata: (funct3_q == F3_REM || funct3_q == F3_REMU) ? rem_res : quot_res
    };

endmodule

`default_nettype wire

/* verilog/ex_lsu_align.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_lsu_align
    import ex_pkg::*;
(
    input  wire ex_issue_t       issue_i,
    input  wire mem_size_e       size_i,
    input  wire [XLEN-1:0]       mem_rdata_i,
    output logic [XLEN-1:0]      addr_o,
    output logic [XLEN-1:0]      load_data_o,
    output logic [XLEN-1:0]      store_data_o
);

    logic [XLEN-1:0] addr;
    logic [1:0]      lane;
    logic [7:0]      rd_byte;
    logic [15:0]     rd_half;
    logic            sext;

    assign addr   = issue_i.op1 + issue_i.op2;
    assign lane   = addr[1:0];
    assign addr_o = addr;

    assign rd_byte = mem_rdata_i[{lane, 3'b000} +: 8];
    assign rd_half = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
    // lbu and lhu have funct3 bit 2 set
    assign sext    = ~issue_i.inst.r.funct3[2];

    always_comb begin
        case (size_i)
            SIZE_BYTE: load_data_o = {{(XLEN-8){sext & rd_byte[7]}}, rd_byte};
            SIZE_HALF: load_data_o = {{(XLEN-16){sext & rd_half[15]}}, rd_half};
            default:   load_data_o = mem_rdata_i;
        endcase
    end

    // merge into the word read back from memory
    always_comb begin
        store_data_o = mem_rdata_i;
        case (size_i)
            SIZE_BYTE: store_data_o[{lane, 3'b000} +: 8] = issue_i.reg2_rdata[7:0];
            SIZE_HALF: store_data_o[{lane[1], 4'b0000} +: 16] = issue_i.reg2_rdata[15:0];
            default:   store_data_o = issue_i.reg2_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // integer group funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_DIV  = 3'b100;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REM  = 3'b110;
    localparam logic [2:0] F3_REMU = 3'b111;

    typedef enum logic [2:0] {
        OP_NONE, OP_ALU, OP_LOAD, OP_STORE, OP_BRANCH, OP_JUMP, OP_FENCE, OP_DIV
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_ZERO
    } alu_op_e;

    // same code as the bus size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        inst_u                 inst;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       op1_jump;
        logic [XLEN-1:0]       op2_jump;
        logic [XLEN-1:0]       reg1_rdata;
        logic [XLEN-1:0]       reg2_rdata;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] reg_waddr;
    } ex_issue_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } rf_wr_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] raddr;
        logic [XLEN-1:0] waddr;
        logic [XLEN-1:0] wdata;
        mem_size_e       size;
    } mem_req_t;

    typedef struct packed {
        logic            hold;
        logic            jump;
        logic [XLEN-1:0] jump_addr;
    } redirect_t;

    typedef struct packed {
        logic [XLEN-1:0]       dividend;
        logic [XLEN-1:0]       divisor;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
    } div_req_t;

endpackage

`default_nettype wire

/* verilog/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top
    import ex_pkg::*;
(
    input  wire             clk_i,
    input  wire             rst_n_i,
    input  wire ex_issue_t  issue_i,
    input  wire [XLEN-1:0]  mem_rdata_i,
    input  wire             int_assert_i,
    input  wire [XLEN-1:0]  int_addr_i,
    output rf_wr_t          rf_wr_o,
    output mem_req_t        mem_o,
    output redirect_t       redirect_o
);

    op_class_e       op_class;
    alu_op_e         alu_op;
    mem_size_e       size;
    logic [XLEN-1:0] alu_result;
    logic            taken;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] store_data;
    logic            div_start;
    div_req_t        div_req;
    logic            div_busy;
    rf_wr_t          div_wr;

    ex_decode i_decode (
        .issue_i    (issue_i),
        .op_class_o (op_class),
        .alu_op_o   (alu_op),
        .size_o     (size)
    );

    ex_alu i_alu (
        .issue_i    (issue_i),
        .op_class_i (op_class),
        .alu_op_i   (alu_op),
        .result_o   (alu_result),
        .taken_o    (taken)
    );

    ex_lsu_align i_lsu_align (
        .issue_i      (issue_i),
        .size_i       (size),
        .mem_rdata_i  (mem_rdata_i),
        .addr_o       (addr),
        .load_data_o  (load_data),
        .store_data_o (store_data)
    );

    ex_commit i_commit (
        .issue_i      (issue_i),
        .op_class_i   (op_class),
        .size_i       (size),
        .alu_result_i (alu_result),
        .taken_i      (taken),
        .addr_i       (addr),
        .load_data_i  (load_data),
        .store_data_i (store_data),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .div_busy_i   (div_busy),
        .div_wr_i     (div_wr),
        .div_start_o  (div_start),
        .div_req_o    (div_req),
        .rf_wr_o      (rf_wr_o),
        .mem_o        (mem_o),
        .redirect_o   (redirect_o)
    );

    ex_divider i_divider (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (div_start),
        .req_i   (div_req),
        .busy_o  (div_busy),
        .wr_o    (div_wr)
    );

endmodule

`default_nettype wire
